// File: verilog/user_io_pkg.sv
/*
 * shared types and constants for the host link: spi command codes,
 * core-type reply, register widths, buttons union and keyboard prefixes
 */
`default_nettype none

package user_io_pkg;

	// one spi byte
	typedef logic [7:0] byte_t;

	// byte position within a transfer, saturates at all ones
	typedef logic [9:0] byte_idx_t;

	typedef logic [31:0] joy_t;
	typedef logic [63:0] status_t;
	typedef logic [6:0]  core_mod_t;

	// host command codes
	localparam byte_t cmd_buttons  = 8'h01;
	localparam byte_t cmd_kbd      = 8'h05;
	localparam byte_t cmd_status8  = 8'h15;
	localparam byte_t cmd_status64 = 8'h1e;
	localparam byte_t cmd_core_mod = 8'h21;
	localparam byte_t cmd_joy0     = 8'h60;
	localparam byte_t cmd_joy1     = 8'h61;

	// reply shifted out during the command byte, 8 bit core
	localparam byte_t core_type = 8'ha4;

	// keyboard scan code prefixes
	localparam byte_t kbd_prefix_ext   = 8'he0;
	localparam byte_t kbd_prefix_break = 8'hf0;

	// buttons byte, stored raw and read back as fields
	typedef union packed {
		byte_t raw;
		struct packed {
			logic       spare;
			logic       no_csync;
			logic       ypbpr;
			logic       scandoubler_disable;
			logic [1:0] switches;
			logic [1:0] buttons;
		} f;
	} but_sw_u;

endpackage

`default_nettype wire

// File: verilog/host_write_if.sv
/*
 * decoded host write bus from the command decoder to the
 * register block and the keyboard block
 */
`timescale 1ns/1ps
`default_nettype none

interface host_write_if import user_io_pkg::*; ();

	// one cycle write strobe
	logic      wr;
	// command latched from byte 0 of the transfer
	byte_t     cmd;
	// payload position, 1 is the first byte after the command
	byte_idx_t idx;
	byte_t     data;

	modport src (output wr, cmd, idx, data);
	modport dst (input wr, cmd, idx, data);

endinterface

`default_nettype wire

// File: verilog/spi_byte_link.sv
/*
 * spi slave oversampled in clk_sys: line sync, bit and byte framing,
 * byte assembly and the core-type reply on miso
 */
`timescale 1ns/1ps
`default_nettype none

module spi_byte_link import user_io_pkg::*; (
	input  wire       clk_sys,
	input  wire       SPI_SS_IO,
	input  wire       spi_clk,
	input  wire       spi_mosi,
	output logic      spi_miso,
	output byte_t     rx_byte,
	output logic      rx_strobe,
	output byte_idx_t rx_idx
);

	// sck history, two sync stages plus one for edge detection
	logic [2:0] sck_sync;
	logic [1:0] mosi_sync;
	logic       sck_rise;
	logic       sck_fall;
	logic       mosi_s;

	// framing state, cleared while the slave select is high
	logic [2:0] bit_cnt;
	byte_idx_t  byte_cnt;
	logic [6:0] shift_r;

	// sync flops keep running across transfers so an idle-high
	// sck does not look like a fresh edge when select drops
	always_ff @(posedge clk_sys) begin
		sck_sync  <= {sck_sync[1:0], spi_clk};
		mosi_sync <= {mosi_sync[0], spi_mosi};
	end

	// edges seen in the third cycle after the pin moves
	assign sck_rise = sck_sync[1] & ~sck_sync[2];
	assign sck_fall = ~sck_sync[1] & sck_sync[2];
	assign mosi_s   = mosi_sync[1];

	always_ff @(posedge clk_sys or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			bit_cnt   <= '0;
			byte_cnt  <= '0;
			shift_r   <= '0;
			rx_strobe <= 1'b0;
			spi_miso  <= 1'b0;
		end else begin
			rx_strobe <= 1'b0;
			if (sck_rise) begin
				// msb first
				shift_r <= {shift_r[5:0], mosi_s};
				bit_cnt <= bit_cnt + 3'd1;
				if (bit_cnt == 3'd7) begin
					rx_strobe <= 1'b1;
					if (byte_cnt != '1)
						byte_cnt <= byte_cnt + 1'b1;
				end
			end
			// host samples on the rising edge; with sck idling high the
			// first falling edge of a transfer already presents bit 7
			if (sck_fall)
				spi_miso <= (byte_cnt == '0) ? core_type[~bit_cnt] : 1'b0;
		end
	end

	// received byte and its position, valid with rx_strobe
	always_ff @(posedge clk_sys) begin
		if (sck_rise && bit_cnt == 3'd7) begin
			rx_byte <= {shift_r, mosi_s};
			rx_idx  <= byte_cnt;
		end
	end

	// no byte may be reported outside a transfer
	a_no_strobe_idle: assert property (@(posedge clk_sys) SPI_SS_IO |-> !rx_strobe);

endmodule

`default_nettype wire

// File: verilog/host_cmd_decoder.sv
/*
 * command latch and payload forwarding onto the host write bus,
 * with per-command payload length limits
 */
`timescale 1ns/1ps
`default_nettype none

module host_cmd_decoder import user_io_pkg::*; (
	input wire          clk_sys,
	input wire          SPI_SS_IO,
	input wire byte_t   rx_byte,
	input wire          rx_strobe,
	input wire byte_idx_t rx_idx,
	host_write_if.src   wr_port
);

	byte_t     cmd_r;
	logic      wr_r;
	byte_idx_t idx_r;
	byte_t     data_r;

	// payload length of each known command, unknown ones pass
	// through unlimited and are sorted out by the receivers
	function automatic logic in_range(input byte_t cmd, input byte_idx_t idx);
		logic ok;
		case (cmd)
			cmd_status64: ok = (idx <= 10'd8);
			cmd_joy0, cmd_joy1: ok = (idx <= 10'd4);
			cmd_buttons, cmd_status8, cmd_core_mod: ok = (idx == 10'd1);
			default: ok = 1'b1;
		endcase
		return ok;
	endfunction

	always_ff @(posedge clk_sys or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			cmd_r <= '0;
			wr_r  <= 1'b0;
		end else begin
			wr_r <= 1'b0;
			if (rx_strobe) begin
				if (rx_idx == '0)
					cmd_r <= rx_byte;
				else
					wr_r <= in_range(cmd_r, rx_idx);
			end
		end
	end

	// payload registers, sampled with every received byte
	always_ff @(posedge clk_sys) begin
		if (rx_strobe) begin
			idx_r  <= rx_idx;
			data_r <= rx_byte;
		end
	end

	assign wr_port.wr   = wr_r;
	assign wr_port.cmd  = cmd_r;
	assign wr_port.idx  = idx_r;
	assign wr_port.data = data_r;

	// bytes are at least eight sck periods apart
	a_wr_single: assert property (@(posedge clk_sys) disable iff (SPI_SS_IO)
		wr_r |=> !wr_r);

endmodule

`default_nettype wire

// File: verilog/core_config_regs.sv
/*
 * core configuration registers: buttons and switches, two digital
 * joysticks, 64-bit status word and core variant
 */
`timescale 1ns/1ps
`default_nettype none

module core_config_regs import user_io_pkg::*; (
	input wire        clk_sys,
	host_write_if.dst wr_port,
	output logic [1:0] buttons,
	output logic [1:0] switches,
	output logic      scandoubler_disable,
	output logic      ypbpr,
	output logic      no_csync,
	output joy_t      joystick_0,
	output joy_t      joystick_1,
	output status_t   status,
	output core_mod_t core_mod
);

	// held across transfers, power-up values only
	but_sw_u   but_sw = '0;
	joy_t      joy_r [2] = '{default: '0};
	status_t   status_r = '0;
	core_mod_t core_mod_r = 7'd1;

	// byte lane, payload byte 1 is the least significant
	logic [2:0] lane;

	assign lane = 3'(wr_port.idx - 1'b1);

	always_ff @(posedge clk_sys) begin
		if (wr_port.wr) begin
			case (wr_port.cmd)
				cmd_buttons: but_sw.raw <= wr_port.data;
				// joy0 and joy1 differ only in the command lsb
				cmd_joy0, cmd_joy1:
					joy_r[wr_port.cmd[0]][{lane[1:0], 3'b000} +: 8] <= wr_port.data;
				// short status write clears the upper bytes
				cmd_status8: status_r <= {56'd0, wr_port.data};
				cmd_status64: status_r[{lane, 3'b000} +: 8] <= wr_port.data;
				cmd_core_mod: core_mod_r <= wr_port.data[6:0];
				// keyboard and unknown commands are not ours
				default: ;
			endcase
		end
	end

	// field view of the buttons byte
	assign buttons             = but_sw.f.buttons;
	assign switches            = but_sw.f.switches;
	assign scandoubler_disable = but_sw.f.scandoubler_disable;
	assign ypbpr               = but_sw.f.ypbpr;
	assign no_csync            = but_sw.f.no_csync;

	assign joystick_0 = joy_r[0];
	assign joystick_1 = joy_r[1];
	assign status     = status_r;
	assign core_mod   = core_mod_r;

endmodule

`default_nettype wire

// File: verilog/ps2_keyboard.sv
/*
 * keyboard path: key event decode, 8-byte scan code fifo,
 * ps/2 clock divider and frame transmitter
 */
`timescale 1ns/1ps
`default_nettype none

module ps2_keyboard import user_io_pkg::*; #(
	parameter int PS2DIV = 100
) (
	input wire        clk_sys,
	host_write_if.dst wr_port,
	output byte_t     key_code,
	output logic      key_pressed,
	output logic      key_extended,
	output logic      key_strobe,
	output logic      ps2_kbd_clk,
	output logic      ps2_kbd_data
);

	localparam int div_w = (PS2DIV > 0) ? $clog2(PS2DIV + 1) : 1;
	localparam logic [3:0] tx_idle = 4'd0;
	localparam logic [3:0] tx_stop = 4'd11;

	logic  kbd_wr;
	logic  ext_now;
	logic  brk_now;
	// prefixes seen so far in this transfer
	logic  ext_r = 1'b0;
	logic  brk_r = 1'b0;
	byte_t code_r = '0;
	logic  pressed_r = 1'b0;
	logic  extended_r = 1'b0;
	logic  strobe_r = 1'b0;

	// fifo, one extra pointer bit tells full from empty
	byte_t      fifo_mem [8];
	logic [3:0] wptr = '0;
	logic [3:0] rptr = '0;
	logic       fifo_empty;
	logic       fifo_full;

	logic [div_w-1:0] div_cnt = '0;
	logic             ps2_clk_r = 1'b0;
	logic             rise_tick;

	logic [3:0] tx_state = tx_idle;
	byte_t      tx_shift;
	logic       tx_parity;
	// line idles high
	logic       data_r = 1'b1;

	assign kbd_wr = wr_port.wr && (wr_port.cmd == cmd_kbd);

	// first payload byte starts with no prefix
	assign ext_now = (wr_port.idx == 10'd1) ? 1'b0 : ext_r;
	assign brk_now = (wr_port.idx == 10'd1) ? 1'b0 : brk_r;

	always_ff @(posedge clk_sys) begin
		strobe_r <= 1'b0;
		if (kbd_wr) begin
			ext_r <= ext_now | (wr_port.data == kbd_prefix_ext);
			brk_r <= brk_now | (wr_port.data == kbd_prefix_break);
			if (wr_port.data != kbd_prefix_ext && wr_port.data != kbd_prefix_break) begin
				code_r     <= wr_port.data;
				extended_r <= ext_now;
				pressed_r  <= ~brk_now;
				strobe_r   <= 1'b1;
			end
		end
	end

	assign fifo_empty = (wptr == rptr);
	assign fifo_full  = (wptr[2:0] == rptr[2:0]) && (wptr[3] != rptr[3]);

	// every keyboard byte is queued, prefixes too; full drops the byte
	always_ff @(posedge clk_sys) begin
		if (kbd_wr && !fifo_full) begin
			fifo_mem[wptr[2:0]] <= wr_port.data;
			wptr <= wptr + 4'd1;
		end
	end

	// ps/2 clock toggles every PS2DIV+1 cycles
	always_ff @(posedge clk_sys) begin
		if (div_cnt == div_w'(PS2DIV)) begin
			div_cnt   <= '0;
			ps2_clk_r <= ~ps2_clk_r;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// cycle where the divided clock goes high
	assign rise_tick = (div_cnt == div_w'(PS2DIV)) && !ps2_clk_r;

	// frame: start 0, 8 data lsb first, odd parity, stop 1
	// data moves with the clock rise, device samples on the fall
	always_ff @(posedge clk_sys) begin
		if (rise_tick) begin
			if (tx_state == tx_idle) begin
				if (!fifo_empty) begin
					tx_shift  <= fifo_mem[rptr[2:0]];
					tx_parity <= ~^fifo_mem[rptr[2:0]];
					rptr      <= rptr + 4'd1;
					data_r    <= 1'b0;
					tx_state  <= 4'd1;
				end
			end else begin
				if (tx_state <= 4'd8) begin
					data_r   <= tx_shift[0];
					tx_shift <= {1'b0, tx_shift[7:1]};
				end else if (tx_state == 4'd9) begin
					data_r <= tx_parity;
				end else if (tx_state == 4'd10) begin
					data_r <= 1'b1;
				end
				tx_state <= (tx_state == tx_stop) ? tx_idle : tx_state + 4'd1;
			end
		end
	end

	// clock held high while nothing is being sent
	assign ps2_kbd_clk  = ps2_clk_r | (tx_state == tx_idle);
	assign ps2_kbd_data = data_r;

	assign key_code     = code_r;
	assign key_pressed  = pressed_r;
	assign key_extended = extended_r;
	assign key_strobe   = strobe_r;

	// transmitter state never runs past the stop bit
	a_tx_stop: assert property (@(posedge clk_sys) tx_state <= tx_stop);

endmodule

`default_nettype wire

// File: verilog/user_io.sv
/*
 * host link top: spi slave, command decoder, config registers
 * and ps/2 keyboard
 */
`timescale 1ns/1ps
`default_nettype none

module user_io import user_io_pkg::*; #(
	parameter int PS2DIV = 100
) (
	input  wire            clk_sys,
	input  wire            SPI_SS_IO,
	input  wire            SPI_CLK,
	input  wire            SPI_MOSI,
	output wire            SPI_MISO,
	output wire [1:0]      buttons,
	output wire [1:0]      switches,
	output wire            scandoubler_disable,
	output wire            ypbpr,
	output wire            no_csync,
	output wire joy_t      joystick_0,
	output wire joy_t      joystick_1,
	output wire status_t   status,
	output wire core_mod_t core_mod,
	output wire byte_t     key_code,
	output wire            key_pressed,
	output wire            key_extended,
	output wire            key_strobe,
	output wire            ps2_kbd_clk,
	output wire            ps2_kbd_data
);

	// spi byte stream into the decoder
	byte_t     rx_byte;
	logic      rx_strobe;
	byte_idx_t rx_idx;

	host_write_if host_wr ();

	spi_byte_link u_spi (
		.clk_sys   (clk_sys),
		.SPI_SS_IO (SPI_SS_IO),
		.spi_clk   (SPI_CLK),
		.spi_mosi  (SPI_MOSI),
		.spi_miso  (SPI_MISO),
		.rx_byte   (rx_byte),
		.rx_strobe (rx_strobe),
		.rx_idx    (rx_idx)
	);

	host_cmd_decoder u_dec (
		.clk_sys   (clk_sys),
		.SPI_SS_IO (SPI_SS_IO),
		.rx_byte   (rx_byte),
		.rx_strobe (rx_strobe),
		.rx_idx    (rx_idx),
		.wr_port   (host_wr.src)
	);

	core_config_regs u_regs (
		.clk_sys             (clk_sys),
		.wr_port             (host_wr.dst),
		.buttons             (buttons),
		.switches            (switches),
		.scandoubler_disable (scandoubler_disable),
		.ypbpr               (ypbpr),
		.no_csync            (no_csync),
		.joystick_0          (joystick_0),
		.joystick_1          (joystick_1),
		.status              (status),
		.core_mod            (core_mod)
	);

	ps2_keyboard #(
		.PS2DIV (PS2DIV)
	) u_kbd (
		.clk_sys      (clk_sys),
		.wr_port      (host_wr.dst),
		.key_code     (key_code),
		.key_pressed  (key_pressed),
		.key_extended (key_extended),
		.key_strobe   (key_strobe),
		.ps2_kbd_clk  (ps2_kbd_clk),
		.ps2_kbd_data (ps2_kbd_data)
	);

endmodule

`default_nettype wire

// File: tests/tb_clock_gen.sv
/*
 * free-running testbench clock, 50% duty cycle
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int period_ns = 100
) (
	output logic clk
);

	// low at time zero so the first edge is a rising one
	initial clk = 1'b0;

	always #(period_ns / 2) clk = ~clk;

endmodule

`default_nettype wire

// File: tests/tb_user_io.sv
/*
 * host link testbench: spi transfers into the dut, ps/2 frame capture,
 * key event capture, register checks and a cycle limit
 */
`timescale 1ns/1ps
`default_nettype none

module tb_user_io import user_io_pkg::*; ();

	// one spi byte is 8 bits of two 6-cycle phases
	localparam int byte_cycles = 8 * 2 * 6;
	// 35 spi bytes over all transfers, plus select gaps and ps/2 drain
	localparam int max_cycles = 5 * 35 * byte_cycles + 3000;
	localparam logic [7:0] reply_exp = 8'ha4;

	logic       clk_sys;
	logic       spi_ss_io;
	logic       spi_clk;
	logic       spi_mosi;
	logic       spi_miso;
	logic [1:0] buttons;
	logic [1:0] switches;
	logic       scandoubler_disable;
	logic       ypbpr;
	logic       no_csync;
	joy_t       joystick_0;
	joy_t       joystick_1;
	status_t    status;
	core_mod_t  core_mod;
	byte_t      key_code;
	logic       key_pressed;
	logic       key_extended;
	logic       key_strobe;
	logic       ps2_kbd_clk;
	logic       ps2_kbd_data;

	int          errors = 0;
	int          checks = 0;
	int          cycle_cnt = 0;
	byte_t       tx_q [$];
	// key events as {extended, pressed, code}
	logic [9:0]  key_q [$];
	byte_t       ps2_exp_q [$];
	logic [10:0] frame = '0;
	int          frame_bits = 0;
	logic        kclk_prev = 1'b1;

	tb_clock_gen #(.period_ns(100)) u_clk (.clk(clk_sys));

	user_io #(.PS2DIV(3)) uut (
		.clk_sys             (clk_sys),
		.SPI_SS_IO           (spi_ss_io),
		.SPI_CLK             (spi_clk),
		.SPI_MOSI            (spi_mosi),
		.SPI_MISO            (spi_miso),
		.buttons             (buttons),
		.switches            (switches),
		.scandoubler_disable (scandoubler_disable),
		.ypbpr               (ypbpr),
		.no_csync            (no_csync),
		.joystick_0          (joystick_0),
		.joystick_1          (joystick_1),
		.status              (status),
		.core_mod            (core_mod),
		.key_code            (key_code),
		.key_pressed         (key_pressed),
		.key_extended        (key_extended),
		.key_strobe          (key_strobe),
		.ps2_kbd_clk         (ps2_kbd_clk),
		.ps2_kbd_data        (ps2_kbd_data)
	);

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("ERROR %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// frame bits: 0 start, 8:1 data lsb first, 9 parity, 10 stop
	task automatic check_frame(input logic [10:0] fr);
		byte_t exp;
		if (ps2_exp_q.size() == 0) begin
			errors++;
			$display("ERROR ps2 frame: a frame carrying %h arrived with none expected",
				fr[8:1]);
		end else begin
			exp = ps2_exp_q.pop_front();
			check_value("ps2 data", 64'(exp), 64'(fr[8:1]));
		end
		check_value("ps2 start bit", 64'd0, 64'(fr[0]));
		check_value("ps2 odd parity", 64'd1, 64'(^fr[9:1]));
		check_value("ps2 stop bit", 64'd1, 64'(fr[10]));
	endtask

	// mode 3 host, msb first, clock idles high
	task automatic send_byte(input byte_t tx, output byte_t rx);
		for (int i = 7; i >= 0; i--) begin
			spi_clk  = 1'b0;
			spi_mosi = tx[i];
			repeat (6) @(negedge clk_sys);
			// miso read just before the rising edge
			rx[i]   = spi_miso;
			spi_clk = 1'b1;
			repeat (6) @(negedge clk_sys);
		end
	endtask

	// sends tx_q as one transfer, byte 0 is the command
	task automatic spi_transfer(input string name);
		byte_t rx;
		spi_ss_io = 1'b0;
		repeat (4) @(negedge clk_sys);
		foreach (tx_q[n]) begin
			send_byte(tx_q[n], rx);
			if (n == 0)
				check_value({name, " miso reply"}, 64'(reply_exp), 64'(rx));
			else
				check_value({name, " miso payload"}, 64'd0, 64'(rx));
		end
		// last byte needs a few cycles to reach its register
		repeat (4) @(negedge clk_sys);
		spi_ss_io = 1'b1;
		repeat (4) @(negedge clk_sys);
		check_value({name, " miso idle"}, 64'd0, 64'(spi_miso));
		tx_q.delete();
	endtask

	task automatic joy_transfer(input string name, input byte_t cmd, output joy_t exp);
		byte_t b;
		tx_q.push_back(cmd);
		for (int k = 0; k < 4; k++) begin
			b = 8'($urandom());
			exp[8 * k +: 8] = b;
			tx_q.push_back(b);
		end
		// one byte past the joystick width
		tx_q.push_back(~exp[7:0]);
		spi_transfer(name);
	endtask

	// prefix 0 means a plain code
	task automatic key_transfer(input string name, input byte_t prefix, input byte_t code,
		input logic ext_exp, input logic pressed_exp);
		key_q.delete();
		tx_q.push_back(8'h05);
		if (prefix != 8'h00) begin
			tx_q.push_back(prefix);
			ps2_exp_q.push_back(prefix);
		end
		tx_q.push_back(code);
		ps2_exp_q.push_back(code);
		spi_transfer(name);
		check_value({name, " event count"}, 64'd1, 64'(key_q.size()));
		if (key_q.size() == 1) begin
			check_value({name, " code"}, 64'(code), 64'(key_q[0][7:0]));
			check_value({name, " pressed"}, 64'(pressed_exp), 64'(key_q[0][8]));
			check_value({name, " extended"}, 64'(ext_exp), 64'(key_q[0][9]));
		end
	endtask

	always @(negedge clk_sys) begin
		if (key_strobe)
			key_q.push_back({key_extended, key_pressed, key_code});
	end

	// falling ps/2 clock seen in clk_sys samples, so a short glitch is ignored
	always @(negedge clk_sys) begin
		if (kclk_prev && !ps2_kbd_clk) begin
			frame[frame_bits] = ps2_kbd_data;
			frame_bits++;
			if (frame_bits == 11) begin
				check_frame(frame);
				frame_bits = 0;
			end
		end
		kclk_prev = ps2_kbd_clk;
	end

	always @(posedge clk_sys) begin
		cycle_cnt++;
		if (cycle_cnt > max_cycles) begin
			$display("run stopped at the %0d cycle limit, %0d errors, %0d ps/2 bytes pending",
				max_cycles, errors, ps2_exp_q.size());
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	initial begin
		byte_t b;
		byte_t code;
		joy_t  joy0_exp;
		joy_t  joy1_exp;
		status_t stat_exp;
		void'($urandom(32'h85dd));
		spi_ss_io = 1'b1;
		spi_clk   = 1'b1;
		spi_mosi  = 1'b0;
		repeat (8) @(negedge clk_sys);
		check_value("core_mod at power-up", 64'd1, 64'(core_mod));

		b = 8'($urandom());
		tx_q.push_back(8'h01);
		tx_q.push_back(b);
		spi_transfer("buttons");
		check_value("buttons", 64'(b[1:0]), 64'(buttons));
		check_value("switches", 64'(b[3:2]), 64'(switches));
		check_value("scandoubler_disable", 64'(b[4]), 64'(scandoubler_disable));
		check_value("ypbpr", 64'(b[5]), 64'(ypbpr));
		check_value("no_csync", 64'(b[6]), 64'(no_csync));

		joy_transfer("joystick 0", 8'h60, joy0_exp);
		check_value("joystick 0", 64'(joy0_exp), 64'(joystick_0));
		check_value("joystick 1 untouched", 64'd0, 64'(joystick_1));
		joy_transfer("joystick 1", 8'h61, joy1_exp);
		check_value("joystick 1", 64'(joy1_exp), 64'(joystick_1));
		check_value("joystick 0 kept", 64'(joy0_exp), 64'(joystick_0));

		tx_q.push_back(8'h1e);
		for (int k = 0; k < 8; k++) begin
			b = 8'($urandom());
			stat_exp[8 * k +: 8] = b;
			tx_q.push_back(b);
		end
		spi_transfer("status64");
		check_value("status64", stat_exp, status);
		b = 8'($urandom());
		tx_q.push_back(8'h15);
		tx_q.push_back(b);
		spi_transfer("status8");
		check_value("status8", {56'd0, b}, status);

		b = 8'($urandom());
		tx_q.push_back(8'h21);
		tx_q.push_back(b);
		spi_transfer("core_mod");
		check_value("core_mod", 64'(b[6:0]), 64'(core_mod));

		// codes below 80 can never look like a prefix
		code = {1'b0, 7'($urandom())};
		key_transfer("key plain", 8'h00, code, 1'b0, 1'b1);
		code = {1'b0, 7'($urandom())};
		key_transfer("key extended", 8'he0, code, 1'b1, 1'b1);
		code = {1'b0, 7'($urandom())};
		key_transfer("key break", 8'hf0, code, 1'b0, 1'b0);

		// wait for the ps/2 stream to drain, then watch for stray frames
		while (ps2_exp_q.size() != 0)
			@(negedge clk_sys);
		repeat (40) @(negedge clk_sys);
		check_value("ps2 partial frame bits", 64'd0, 64'(frame_bits));

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
verilog/user_io_pkg.sv
verilog/host_write_if.sv
verilog/spi_byte_link.sv
verilog/host_cmd_decoder.sv
verilog/core_config_regs.sv
verilog/ps2_keyboard.sv
verilog/user_io.sv
tests/tb_clock_gen.sv
tests/tb_user_io.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_user_io
FILELIST  := files.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)
PASS_MSG  := TEST RESULT: PASS

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
